// ==== include/pe_defines.svh ====
`ifndef PE_DEFINES_SVH
`define PE_DEFINES_SVH

// Kernel taps per output
`define PE_TAPS 3

// Outputs per row; a row carries two more pixels than that
`define PE_ROW_LEN 8

// Rows held in the output buffer for one plane
`define PE_MAX_ROWS 4

// Pixel and weight width
`define PE_DATA_W 8

// Partial sums
`define PE_PSUM_W 24

// Wishbone word address
`define PE_WB_ADDR_W 3

`endif

// ==== src/pe_ctrl_pkg.sv ====
`include "pe_defines.svh"

package pe_ctrl_pkg;

    // Register map, one word per address
    typedef enum logic [`PE_WB_ADDR_W-1:0] {
        REG_KERNEL = 0,
        REG_BIAS   = 1,
        REG_CHAN   = 2,
        REG_CMD    = 3,
        REG_PIXEL  = 4,
        REG_STATUS = 5
    } pe_reg_e;

    // Bit positions inside CHAN, CMD and STATUS words
    localparam int CHAN_FIRST_BIT = 0;
    localparam int CHAN_LAST_BIT  = 1;
    localparam int CMD_LOAD_BIT   = 0;
    localparam int CMD_MID_BIT    = 1;
    localparam int CMD_LAST_BIT   = 2;
    localparam int STAT_READY_BIT = 0;
    localparam int STAT_IDLE_BIT  = 1;

    // Requests pulse for one cycle, channel flags are levels
    typedef struct packed {
        logic load_kernel;
        logic mid_row;
        logic last_row;
        logic first_chan;
        logic last_chan;
    } pe_cmd_t;

    typedef struct packed {
        logic wr_kernel;
        logic row_start;
        logic buf_we;
        logic cnt_en;
        logic cnt_rst_n;
        logic add_bias;
        logic stream_valid;
        logic stream_last;
    } pe_ctrl_t;

endpackage

// ==== src/pe_data_pkg.sv ====
`include "pe_defines.svh"

package pe_data_pkg;

    typedef logic signed [`PE_DATA_W-1:0] pixel_t;
    typedef logic signed [`PE_DATA_W-1:0] weight_t;

    // Weight zero sits in the low byte
    typedef weight_t [`PE_TAPS-1:0] kernel_t;

    typedef logic signed [`PE_PSUM_W-1:0] psum_t;

    typedef struct packed {
        psum_t data;
        logic  last;
    } pe_beat_t;

endpackage

// ==== src/pe_wb_regs.sv ====
`include "pe_defines.svh"

module pe_wb_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cyc,
    input  logic                      stb,
    input  logic                      we,
    input  logic [`PE_WB_ADDR_W-1:0]  adr,
    input  logic [31:0]               dat_w,
    output logic [31:0]               dat_r,
    output logic                      ack,
    input  logic                      row_active,
    input  logic                      idle,
    input  logic                      ready,
    output pe_ctrl_pkg::pe_cmd_t      cmd,
    output pe_data_pkg::kernel_t      kernel,
    output pe_data_pkg::psum_t        bias,
    output logic                      pixel_valid,
    output pe_data_pkg::pixel_t       pixel
);
    import pe_ctrl_pkg::*;

    logic pending;
    logic is_pixel;
    logic accept;
    logic wr_acc;
    logic first_chan;
    logic last_chan;
    logic ready_flag;

    assign pending  = cyc && stb && !ack;
    assign is_pixel = we && (adr == REG_PIXEL);
    // Pixel writes stall until a row is open
    assign accept   = pending && (!is_pixel || row_active);
    assign wr_acc   = accept && we;

    assign cmd.load_kernel = wr_acc && (adr == REG_CMD) && dat_w[CMD_LOAD_BIT];
    assign cmd.mid_row     = wr_acc && (adr == REG_CMD) && dat_w[CMD_MID_BIT];
    assign cmd.last_row    = wr_acc && (adr == REG_CMD) && dat_w[CMD_LAST_BIT];
    assign cmd.first_chan  = first_chan;
    assign cmd.last_chan   = last_chan;

    assign pixel_valid = accept && is_pixel;
    assign pixel       = dat_w[`PE_DATA_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack        <= 1'b0;
            first_chan <= 1'b0;
            last_chan  <= 1'b0;
            ready_flag <= 1'b0;
        end else begin
            ack <= accept;
            // Sticky until the next kernel load
            if (cmd.load_kernel) begin
                ready_flag <= 1'b0;
            end else if (ready) begin
                ready_flag <= 1'b1;
            end
            if (wr_acc && adr == REG_CHAN) begin
                first_chan <= dat_w[CHAN_FIRST_BIT];
                last_chan  <= dat_w[CHAN_LAST_BIT];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_acc && adr == REG_KERNEL) begin
            kernel <= dat_w[`PE_TAPS*`PE_DATA_W-1:0];
        end
        if (wr_acc && adr == REG_BIAS) begin
            bias <= dat_w[`PE_PSUM_W-1:0];
        end
        if (accept && !we) begin
            dat_r <= '0;
            case (adr)
                REG_KERNEL: dat_r <= 32'(kernel);
                REG_BIAS:   dat_r <= 32'(bias);
                REG_CHAN: begin
                    dat_r[CHAN_FIRST_BIT] <= first_chan;
                    dat_r[CHAN_LAST_BIT]  <= last_chan;
                end
                REG_STATUS: begin
                    dat_r[STAT_READY_BIT] <= ready_flag;
                    dat_r[STAT_IDLE_BIT]  <= idle;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== src/pe_buffers_cu.sv ====
module pe_buffers_cu (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pe_ctrl_pkg::pe_cmd_t   cmd,
    input  logic                   out_valid,
    input  logic                   row_done,
    output pe_ctrl_pkg::pe_ctrl_t  ctrl,
    output logic                   row_active,
    output logic                   idle,
    output logic                   ready
);
    import pe_ctrl_pkg::*;

    // Counters held, nothing written or streamed
    localparam pe_ctrl_t CTRL_QUIET = '{cnt_rst_n: 1'b1, default: 1'b0};

    // Second half repeats the first for the last input channel
    typedef enum logic [3:0] {
        S_RESET         = 4'd0,
        S_IDLE          = 4'd1,
        S_LOAD          = 4'd2,
        S_READY         = 4'd3,
        S_WAIT_MID      = 4'd4,
        S_WRITE_MID     = 4'd5,
        S_WAIT_LAST     = 4'd6,
        S_WRITE_LAST    = 4'd7,
        S_RST_CNT       = 4'd8,
        S_IDLE_LC       = 4'd9,
        S_READY_LC      = 4'd10,
        S_WAIT_MID_LC   = 4'd11,
        S_WRITE_MID_LC  = 4'd12,
        S_WAIT_LAST_LC  = 4'd13,
        S_WRITE_LAST_LC = 4'd14,
        S_RST_CNT_LC    = 4'd15
    } state_e;

    state_e state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_RESET;
        end else begin
            case (state)
                S_RESET: state <= S_IDLE;
                S_IDLE: begin
                    if (cmd.load_kernel) begin
                        state <= S_LOAD;
                    end else if (cmd.mid_row) begin
                        state <= S_WAIT_MID;
                    end else if (cmd.last_row) begin
                        state <= S_WAIT_LAST;
                    end else if (cmd.last_chan) begin
                        state <= S_IDLE_LC;
                    end
                end
                // Shared by both halves
                S_LOAD:       state <= cmd.last_chan ? S_READY_LC : S_READY;
                S_READY:      state <= S_IDLE;
                S_WAIT_MID:   state <= S_WRITE_MID;
                S_WRITE_MID:  state <= row_done ? S_IDLE : S_WRITE_MID;
                S_WAIT_LAST:  state <= S_WRITE_LAST;
                S_WRITE_LAST: state <= row_done ? S_RST_CNT : S_WRITE_LAST;
                S_RST_CNT:    state <= S_IDLE;
                S_IDLE_LC: begin
                    if (cmd.load_kernel) begin
                        state <= S_LOAD;
                    end else if (cmd.mid_row) begin
                        state <= S_WAIT_MID_LC;
                    end else if (cmd.last_row) begin
                        state <= S_WAIT_LAST_LC;
                    end else if (!cmd.last_chan) begin
                        state <= S_IDLE;
                    end
                end
                S_READY_LC:      state <= S_IDLE_LC;
                S_WAIT_MID_LC:   state <= S_WRITE_MID_LC;
                S_WRITE_MID_LC:  state <= row_done ? S_IDLE_LC : S_WRITE_MID_LC;
                S_WAIT_LAST_LC:  state <= S_WRITE_LAST_LC;
                S_WRITE_LAST_LC: state <= row_done ? S_RST_CNT_LC : S_WRITE_LAST_LC;
                S_RST_CNT_LC:    state <= S_IDLE_LC;
                default:         state <= S_IDLE;
            endcase
        end
    end

    always_comb begin
        ctrl       = CTRL_QUIET;
        row_active = 1'b0;
        idle       = 1'b0;
        ready      = 1'b0;
        case (state)
            S_RESET, S_RST_CNT, S_RST_CNT_LC: ctrl.cnt_rst_n = 1'b0;
            S_IDLE, S_IDLE_LC:                idle = 1'b1;
            S_LOAD:                           ctrl.wr_kernel = 1'b1;
            S_READY, S_READY_LC:              ready = 1'b1;
            // One cycle of row setup
            S_WAIT_MID, S_WAIT_LAST, S_WAIT_MID_LC, S_WAIT_LAST_LC: begin
                ctrl.row_start = 1'b1;
                row_active     = !row_done;
            end
            S_WRITE_MID, S_WRITE_LAST: begin
                row_active    = !row_done;
                ctrl.buf_we   = out_valid;
                ctrl.cnt_en   = out_valid;
                ctrl.add_bias = cmd.first_chan;
            end
            S_WRITE_MID_LC, S_WRITE_LAST_LC: begin
                row_active        = !row_done;
                ctrl.buf_we       = out_valid;
                ctrl.cnt_en       = out_valid;
                ctrl.add_bias     = cmd.first_chan;
                ctrl.stream_valid = out_valid;
                // Buffer keeps it only on the final column
                ctrl.stream_last  = out_valid && (state == S_WRITE_LAST_LC);
            end
            default: ;
        endcase
    end

endmodule

// ==== src/pe_mac_row.sv ====
`include "pe_defines.svh"

module pe_mac_row (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_kernel,
    input  logic                  row_start,
    input  pe_data_pkg::kernel_t  kernel,
    input  logic                  pixel_valid,
    input  pe_data_pkg::pixel_t   pixel,
    output logic                  out_valid,
    output pe_data_pkg::psum_t    product
);
    import pe_data_pkg::*;

    localparam int CNT_W = $clog2(`PE_TAPS);

    kernel_t          kern_q;
    // Older taps of the window, index zero is the oldest
    pixel_t           hist [`PE_TAPS-1];
    logic [CNT_W-1:0] win_cnt;
    logic             win_full;
    psum_t            tap_sum;

    assign win_full = (win_cnt == CNT_W'(`PE_TAPS - 1));

    // Incoming pixel completes the window as the newest tap
    always_comb begin
        tap_sum = '0;
        for (int i = 0; i < `PE_TAPS - 1; i++) begin
            tap_sum = tap_sum + psum_t'(hist[i]) * psum_t'(weight_t'(kern_q[i]));
        end
        tap_sum = tap_sum + psum_t'(pixel) * psum_t'(weight_t'(kern_q[`PE_TAPS-1]));
    end

    always_ff @(posedge clk) begin
        if (wr_kernel) begin
            kern_q <= kernel;
        end
        if (pixel_valid) begin
            for (int i = 0; i < `PE_TAPS - 2; i++) begin
                hist[i] <= hist[i+1];
            end
            hist[`PE_TAPS-2] <= pixel;
        end
        if (pixel_valid && win_full) begin
            product <= tap_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_cnt   <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= pixel_valid && win_full;
            if (row_start) begin
                win_cnt <= '0;
            end else if (pixel_valid && !win_full) begin
                win_cnt <= win_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== src/pe_output_buffer.sv ====
`include "pe_defines.svh"

module pe_output_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pe_ctrl_pkg::pe_ctrl_t  ctrl,
    input  logic                   pixel_valid,
    input  pe_data_pkg::psum_t     product,
    input  pe_data_pkg::psum_t     bias,
    output logic                   row_done,
    output logic                   m_valid,
    output pe_data_pkg::pe_beat_t  m_beat
);
    import pe_data_pkg::*;

    localparam int DEPTH  = `PE_MAX_ROWS * `PE_ROW_LEN;
    localparam int ADDR_W = $clog2(DEPTH);
    localparam int COL_W  = $clog2(`PE_ROW_LEN + 1);

    psum_t             mem [DEPTH];
    psum_t             rd_q;
    psum_t             wr_data;
    logic [ADDR_W-1:0] wr_addr;
    logic [COL_W-1:0]  col;
    logic              last_col;

    assign row_done = (col == COL_W'(`PE_ROW_LEN));
    assign last_col = (col == COL_W'(`PE_ROW_LEN - 1));

    // First channel starts from the bias, later ones from the stored sum
    assign wr_data = product + (ctrl.add_bias ? bias : rd_q);

    always_ff @(posedge clk) begin
        // Read ahead while the window's last pixel goes in
        if (pixel_valid) begin
            rd_q <= mem[wr_addr];
        end
        if (ctrl.buf_we) begin
            mem[wr_addr] <= wr_data;
        end
        if (ctrl.stream_valid) begin
            m_beat.data <= wr_data;
            m_beat.last <= ctrl.stream_last && last_col;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_addr <= '0;
            col     <= '0;
            m_valid <= 1'b0;
        end else begin
            m_valid <= ctrl.stream_valid;
            // Address runs across mid rows and restarts after a last row
            if (!ctrl.cnt_rst_n) begin
                wr_addr <= '0;
            end else if (ctrl.cnt_en) begin
                wr_addr <= wr_addr + 1'b1;
            end
            if (ctrl.row_start) begin
                col <= '0;
            end else if (ctrl.cnt_en) begin
                col <= col + 1'b1;
            end
        end
    end

endmodule

// ==== src/pe_with_buffers.sv ====
`include "pe_defines.svh"

module pe_with_buffers (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cyc,
    input  logic                      stb,
    input  logic                      we,
    input  logic [`PE_WB_ADDR_W-1:0]  adr,
    input  logic [31:0]               dat_w,
    output logic [31:0]               dat_r,
    output logic                      ack,
    output logic                      m_valid,
    output pe_data_pkg::pe_beat_t     m_beat,
    output logic                      pe_ready,
    output logic                      pe_idle
);
    pe_ctrl_pkg::pe_cmd_t  cmd;
    pe_ctrl_pkg::pe_ctrl_t ctrl;
    pe_data_pkg::kernel_t  kernel;
    pe_data_pkg::psum_t    bias;
    pe_data_pkg::psum_t    product;
    pe_data_pkg::pixel_t   pixel;
    logic                  pixel_valid;
    logic                  out_valid;
    logic                  row_done;
    logic                  row_active;

    pe_wb_regs u_regs (
        .clk(clk), .rst_n(rst_n),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
        .row_active(row_active), .idle(pe_idle), .ready(pe_ready),
        .cmd(cmd), .kernel(kernel), .bias(bias),
        .pixel_valid(pixel_valid), .pixel(pixel)
    );

    pe_buffers_cu u_cu (
        .clk(clk), .rst_n(rst_n), .cmd(cmd),
        .out_valid(out_valid), .row_done(row_done), .ctrl(ctrl),
        .row_active(row_active), .idle(pe_idle), .ready(pe_ready)
    );

    pe_mac_row u_mac (
        .clk(clk), .rst_n(rst_n),
        .wr_kernel(ctrl.wr_kernel), .row_start(ctrl.row_start), .kernel(kernel),
        .pixel_valid(pixel_valid), .pixel(pixel),
        .out_valid(out_valid), .product(product)
    );

    pe_output_buffer u_obuf (
        .clk(clk), .rst_n(rst_n), .ctrl(ctrl),
        .pixel_valid(pixel_valid), .product(product), .bias(bias),
        .row_done(row_done), .m_valid(m_valid), .m_beat(m_beat)
    );

endmodule

// ==== tests/pe_checker.sv ====
`include "pe_defines.svh"

module pe_checker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cyc,
    input  logic                      stb,
    input  logic                      we,
    input  logic [`PE_WB_ADDR_W-1:0]  adr,
    input  logic [31:0]               dat_w,
    input  logic [31:0]               dat_r,
    input  logic                      ack,
    input  logic                      m_valid,
    input  pe_data_pkg::pe_beat_t     m_beat,
    input  logic                      pe_ready,
    input  logic                      pe_idle,
    input  logic                      finish_req,
    output logic                      done,
    output int                        mismatches,
    output int                        failures
);
    import pe_ctrl_pkg::*;
    import pe_data_pkg::*;

    localparam int DEPTH = `PE_MAX_ROWS * `PE_ROW_LEN;

    int      mismatch_cnt = 0;
    int      failure_cnt = 0;
    string   job = "";
    int      plane_expected = 0;
    int      plane_beats;
    int      since_rst;

    // Last transfer seen pending on the bus
    logic                     rec_valid;
    logic                     rec_we;
    logic [`PE_WB_ADDR_W-1:0] rec_adr;
    logic [31:0]              rec_dat;

    // Reference model of the element
    kernel_t kern_reg;
    kernel_t kern_live;
    psum_t   bias_reg;
    logic    first_flag;
    logic    last_flag;
    logic    ready_flag;
    // Ready pulse lands one cycle after the load write's ack
    logic    ready_due;
    logic    row_open;
    logic    row_is_last;
    int      pix_cnt;
    int      addr;
    int      col;
    pixel_t  win [`PE_TAPS];
    psum_t   buf_mem [DEPTH];
    psum_t   exp_data [$];
    logic    exp_last [$];

    assign mismatches = mismatch_cnt;
    assign failures   = failure_cnt;

    task automatic start_job(input string name, input int beats);
        job = name;
        plane_expected = beats;
    endtask

    task automatic take_command(input logic [31:0] d);
        if (d[CMD_LOAD_BIT]) begin
            kern_live  = kern_reg;
            ready_flag = 1'b1;
            ready_due  = 1'b1;
        end else if (d[CMD_MID_BIT] || d[CMD_LAST_BIT]) begin
            row_open    = 1'b1;
            row_is_last = !d[CMD_MID_BIT];
            pix_cnt     = 0;
            col         = 0;
        end
    endtask

    task automatic take_pixel(input pixel_t p);
        int    s;
        psum_t v;
        if (!row_open) begin
            failure_cnt++;
            $display("Pixel write acknowledged in %s while no row was open", job);
            return;
        end
        for (int k = 0; k < `PE_TAPS - 1; k++) begin
            win[k] = win[k+1];
        end
        win[`PE_TAPS-1] = p;
        pix_cnt++;
        if (pix_cnt >= `PE_TAPS) begin
            // Oldest pixel meets weight zero
            s = 0;
            for (int k = 0; k < `PE_TAPS; k++) begin
                s += int'(win[k]) * int'(weight_t'(kern_live[k]));
            end
            v = first_flag ? psum_t'(s) + bias_reg : buf_mem[addr] + psum_t'(s);
            buf_mem[addr] = v;
            if (last_flag) begin
                exp_data.push_back(v);
                exp_last.push_back(row_is_last && col == `PE_ROW_LEN - 1);
            end
            addr++;
            col++;
            if (col == `PE_ROW_LEN) begin
                row_open = 1'b0;
                if (row_is_last) begin
                    addr = 0;
                end
            end
        end
    endtask

    task automatic complete_transfer();
        logic [31:0] exp_stat;
        if (rec_we) begin
            case (rec_adr)
                REG_KERNEL: kern_reg = rec_dat[`PE_TAPS*`PE_DATA_W-1:0];
                REG_BIAS:   bias_reg = rec_dat[`PE_PSUM_W-1:0];
                REG_CHAN: begin
                    first_flag = rec_dat[CHAN_FIRST_BIT];
                    last_flag  = rec_dat[CHAN_LAST_BIT];
                end
                REG_CMD:    take_command(rec_dat);
                REG_PIXEL:  take_pixel(pixel_t'(rec_dat[`PE_DATA_W-1:0]));
                default: ;
            endcase
        end else if (rec_adr == REG_STATUS) begin
            // Status is only read while the element is idle
            exp_stat = '0;
            exp_stat[STAT_IDLE_BIT]  = 1'b1;
            exp_stat[STAT_READY_BIT] = ready_flag;
            if (dat_r !== exp_stat) begin
                mismatch_cnt++;
                $display("Mismatch %s status: expected %h, actual %h", job, exp_stat, dat_r);
            end
        end
    endtask

    task automatic check_beat();
        psum_t e_data;
        logic  e_last;
        if (exp_data.size() == 0) begin
            failure_cnt++;
            $display("Stream beat in %s with no output pending", job);
            return;
        end
        e_data = exp_data.pop_front();
        e_last = exp_last.pop_front();
        if (m_beat.data !== e_data) begin
            mismatch_cnt++;
            $display("Mismatch %s beat %0d data: expected %0d, actual %0d",
                     job, plane_beats, e_data, m_beat.data);
        end
        if (m_beat.last !== e_last) begin
            mismatch_cnt++;
            $display("Mismatch %s beat %0d last: expected %0b, actual %0b",
                     job, plane_beats, e_last, m_beat.last);
        end
        plane_beats++;
        // Plane ends where the stream says it does
        if (m_beat.last) begin
            if (plane_beats != plane_expected) begin
                mismatch_cnt++;
                $display("Mismatch %s beat count: expected %0d, actual %0d",
                         job, plane_expected, plane_beats);
            end
            plane_beats = 0;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            since_rst  = 0;
            rec_valid  = 1'b0;
            ready_flag = 1'b0;
            ready_due  = 1'b0;
            row_open   = 1'b0;
            addr       = 0;
            col        = 0;
            pix_cnt    = 0;
            plane_beats = 0;
            done       = 1'b0;
            foreach (buf_mem[i]) buf_mem[i] = '0;
            exp_data.delete();
            exp_last.delete();
        end else begin
            // One reset state, then idle
            if (since_rst < 2) begin
                since_rst++;
                if (since_rst == 2 && !pe_idle) begin
                    failure_cnt++;
                    $display("pe_idle still low after the reset state");
                end
            end
            if (pe_ready !== ready_due) begin
                mismatch_cnt++;
                $display("Mismatch %s pe_ready: expected %0b, actual %0b",
                         job, ready_due, pe_ready);
            end
            ready_due = 1'b0;
            if (ack && rec_valid) begin
                complete_transfer();
                rec_valid = 1'b0;
            end
            if (cyc && stb && !ack) begin
                rec_valid = 1'b1;
                rec_we    = we;
                rec_adr   = adr;
                rec_dat   = dat_w;
            end
            if (m_valid) begin
                check_beat();
            end
            if (finish_req && !done) begin
                if (exp_data.size() != 0) begin
                    failure_cnt++;
                    $display("%0d expected stream beats never arrived", exp_data.size());
                end
                done = 1'b1;
            end
        end
    end

endmodule

// ==== tests/tb_pe_with_buffers.sv ====
`include "pe_defines.svh"

module tb_pe_with_buffers;
    import pe_ctrl_pkg::*;
    import pe_data_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int N_JOBS      = 5;
    localparam int ROW_PIX     = `PE_ROW_LEN + `PE_TAPS - 1;
    localparam int WRITE_BOUND = 8;
    localparam int MARGIN      = 2000;

    // One job is one input channel of a plane
    typedef struct packed {
        kernel_t kernel;
        psum_t   bias;
        logic    first_chan;
        logic    last_chan;
        int      rows;
        logic    ramp;
        int      beats;
    } job_t;

    logic                     clk;
    logic                     rst_n;
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [`PE_WB_ADDR_W-1:0] adr;
    logic [31:0]              dat_w;
    logic [31:0]              dat_r;
    logic                     ack;
    logic                     m_valid;
    logic                     pe_ready;
    logic                     pe_idle;
    pe_beat_t                 m_beat;
    logic                     finish_req;
    logic                     chk_done;
    int                       mismatches;
    int                       failures;
    int                       limit = 0;
    job_t                     jobs [N_JOBS];
    string                    names [N_JOBS];

    pe_with_buffers uut (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .m_valid(m_valid), .m_beat(m_beat),
        .pe_ready(pe_ready), .pe_idle(pe_idle)
    );

    pe_checker pe_checker (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .m_valid(m_valid), .m_beat(m_beat),
        .pe_ready(pe_ready), .pe_idle(pe_idle), .finish_req(finish_req), .done(chk_done),
        .mismatches(mismatches), .failures(failures)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        wait (limit > 0);
        #(limit);
        $display("Watchdog expired after %0d time units before the run finished", limit);
        $display("TEST FAILED");
        $finish;
    end

    // Called on a falling edge, returns on the falling edge that sees ack
    task automatic bus_write(input pe_reg_e a, input logic [31:0] d);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        dat_w = d;
        do @(negedge clk); while (!ack);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic bus_read(input pe_reg_e a);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        do @(negedge clk); while (!ack);
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic wait_idle();
        while (!pe_idle) @(negedge clk);
    endtask

    // Pixel write with no row open, then withdrawn
    task automatic hold_pixel_while_idle(input int cycles);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = REG_PIXEL;
        dat_w = 32'h5a;
        repeat (cycles) @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic run_job(input int j);
        pixel_t      pix;
        logic [31:0] chan_word;
        chan_word = (32'(jobs[j].first_chan) << CHAN_FIRST_BIT)
                  | (32'(jobs[j].last_chan) << CHAN_LAST_BIT);
        pe_checker.start_job(names[j], jobs[j].beats);
        bus_write(REG_CHAN, chan_word);
        bus_write(REG_BIAS, 32'(jobs[j].bias));
        bus_write(REG_KERNEL, 32'(jobs[j].kernel));
        wait_idle();
        bus_write(REG_CMD, 32'(1) << CMD_LOAD_BIT);
        wait_idle();
        bus_read(REG_STATUS);
        for (int r = 0; r < jobs[j].rows; r++) begin
            // A row command is only seen in idle
            wait_idle();
            if (j == 0 && r == 0) begin
                hold_pixel_while_idle(8);
            end
            if (r == jobs[j].rows - 1) begin
                bus_write(REG_CMD, 32'(1) << CMD_LAST_BIT);
            end else begin
                bus_write(REG_CMD, 32'(1) << CMD_MID_BIT);
            end
            for (int i = 0; i < ROW_PIX; i++) begin
                pix = jobs[j].ramp ? pixel_t'(r * 16 + i * 9 - 40) : pixel_t'($urandom);
                bus_write(REG_PIXEL, {24'd0, pix});
            end
        end
        wait_idle();
    endtask

    initial begin
        void'($urandom(32'ha14e_7b85));
        rst_n      = 1'b0;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = '0;
        dat_w      = '0;
        finish_req = 1'b0;

        // kernel, bias, first, last, rows, ramp, expected beats
        jobs[0] = '{24'h03_02_01, 24'sd10, 1'b1, 1'b1, 2, 1'b1, 16};
        names[0] = "single_plane";
        jobs[1] = '{24'hfe_05_ff, -24'sd300, 1'b1, 1'b0, 3, 1'b0, 0};
        names[1] = "multi_chan0";
        jobs[2] = '{24'h04_f9_02, 24'sd0, 1'b0, 1'b0, 3, 1'b0, 0};
        names[2] = "multi_chan1";
        jobs[3] = '{24'h01_01_01, 24'sd0, 1'b0, 1'b1, 3, 1'b1, 24};
        names[3] = "multi_chan2";
        jobs[4] = '{24'h7f_80_03, 24'sd1234, 1'b1, 1'b1, 4, 1'b0, 32};
        names[4] = "fresh_plane";

        limit = MARGIN;
        for (int j = 0; j < N_JOBS; j++) begin
            limit += jobs[j].rows * ROW_PIX * WRITE_BOUND * CLK_PERIOD;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        pe_checker.start_job("after_reset", 0);
        repeat (3) @(negedge clk);
        bus_read(REG_STATUS);
        for (int j = 0; j < N_JOBS; j++) begin
            run_job(j);
        end

        finish_req = 1'b1;
        while (!chk_done) @(negedge clk);
        $display("Run complete: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
src/pe_ctrl_pkg.sv
src/pe_data_pkg.sv
src/pe_wb_regs.sv
src/pe_buffers_cu.sv
src/pe_mac_row.sv
src/pe_output_buffer.sv
src/pe_with_buffers.sv
tests/pe_checker.sv
tests/tb_pe_with_buffers.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f \
    --top-module tb_pe_with_buffers -Mdir obj_dir -o sim

./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST OK" sim.log
exit 0
